//--- Makefile
# Verilator flow for the twiddle-factor multiplier.
# Any variable below can be overridden on the command line.

VERILATOR ?= verilator
FILELIST  ?= build.f
TB_TOP    ?= twiddle_gen_tb
RTL_TOP   ?= twiddle_gen_top
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing
PASS_MSG  ?= sim passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		--Mdir $(OBJ_DIR) -o $(TB_TOP)
	@out="$$(./$(OBJ_DIR)/$(TB_TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- build.f
rtl/twiddle_pkg.sv
rtl/mod_mul.sv
rtl/operand_select.sv
rtl/product_stage.sv
rtl/scale_stage.sv
rtl/twiddle_gen_top.sv
verification/tb_clock.sv
verification/twiddle_gen_tb.sv

//--- rtl/mod_mul.sv
`timescale 1ns/1ps

module mod_mul (
    input  logic               clk,
    input  logic               rst_n,
    input  twiddle_pkg::word_t a,
    input  twiddle_pkg::word_t b,
    input  twiddle_pkg::word_t n,
    output twiddle_pkg::word_t p
);
    import twiddle_pkg::*;

    logic [2*WORD_W-1:0] full_q;
    word_t               n_q;
    word_t               rem;

    // First cycle: full product, with the modulus kept beside it.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            full_q <= '0;
            n_q <= '0;
        end else begin
            full_q <= (2*WORD_W)'(a) * (2*WORD_W)'(b);
            n_q <= n;
        end
    end

    // A zero modulus only shows up while the pipe is still empty.
    assign rem = (n_q == '0) ? '0 : word_t'(full_q % (2*WORD_W)'(n_q));

    // Second cycle: the remainder always fits in one word.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            p <= '0;
        end else begin
            p <= rem;
        end
    end

endmodule

//--- rtl/operand_select.sv
`timescale 1ns/1ps

module operand_select (
    input  logic                      clk,
    input  logic                      rst_n,
    input  twiddle_pkg::fft_stage_e   fft_stage,
    input  twiddle_pkg::lane_vec_t    v0_lanes,
    input  twiddle_pkg::lane_vec_t    v1_lanes,
    input  twiddle_pkg::lane_vec_t    v2_lanes,
    output twiddle_pkg::operand_set_t sel
);
    import twiddle_pkg::*;

    operand_set_t next_sel;

    // A factor that the stage does not use is replaced by the
    // multiplicative identity, so the datapath never looks at the stage.
    always_comb begin
        next_sel.v0 = v0_lanes;
        next_sel.v1 = v1_lanes;
        next_sel.v2 = v2_lanes;
        if (fft_stage == FFT_STAGE_3) begin
            next_sel.v0 = {LANES{word_t'(1)}};
        end
        if (fft_stage == FFT_STAGE_2 || fft_stage == FFT_STAGE_3) begin
            next_sel.v1 = {LANES{word_t'(1)}};
        end
        if (fft_stage != FFT_STAGE_0) begin
            next_sel.v2 = {LANES{word_t'(1)}};
        end
    end

    // The selected set travels as one item, so items of different
    // stages can share the pipeline.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sel <= '0;
        end else begin
            sel <= next_sel;
        end
    end

endmodule

//--- rtl/product_stage.sv
`timescale 1ns/1ps

module product_stage (
    input  logic                      clk,
    input  logic                      rst_n,
    input  twiddle_pkg::operand_set_t sel,
    input  twiddle_pkg::word_t        modulus,
    output twiddle_pkg::lane_vec_t    prod,
    output twiddle_pkg::lane_vec_t    v2_aligned
);
    import twiddle_pkg::*;

    lane_vec_t v2_pipe [MUL_LATENCY];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // First product, v0 x v1 mod n
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Lane 0 is never multiplied.
    assign prod[0] = '0;

    for (genvar i = 1; i < LANES; i++) begin : g_lane
        mod_mul u_mul (
            .clk   (clk),
            .rst_n (rst_n),
            .a     (sel.v0[i]),
            .b     (sel.v1[i]),
            .n     (modulus),
            .p     (prod[i])
        );
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // v2 delay
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // All lanes, lane 0 included, wait as long as the multiplier takes.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < MUL_LATENCY; s++) begin
                v2_pipe[s] <= '0;
            end
        end else begin
            v2_pipe[0] <= sel.v2;
            for (int s = 1; s < MUL_LATENCY; s++) begin
                v2_pipe[s] <= v2_pipe[s-1];
            end
        end
    end

    assign v2_aligned = v2_pipe[MUL_LATENCY-1];

endmodule

//--- rtl/scale_stage.sv
`timescale 1ns/1ps

module scale_stage (
    input  logic                   clk,
    input  logic                   rst_n,
    input  twiddle_pkg::lane_vec_t prod,
    input  twiddle_pkg::lane_vec_t v2_aligned,
    input  twiddle_pkg::word_t     modulus,
    output twiddle_pkg::lane_vec_t twiddle
);
    import twiddle_pkg::*;

    word_t     lane0_pipe [MUL_LATENCY];
    lane_vec_t scaled;

    // Second product, (v0 x v1) x v2 mod n.
    for (genvar i = 1; i < LANES; i++) begin : g_lane
        mod_mul u_mul (
            .clk   (clk),
            .rst_n (rst_n),
            .a     (prod[i]),
            .b     (v2_aligned[i]),
            .n     (modulus),
            .p     (scaled[i])
        );
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Lane 0 bypass
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Lane 0 carries v2 straight through, already forced to 1 outside
    // stage 0 at the input.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < MUL_LATENCY; s++) begin
                lane0_pipe[s] <= '0;
            end
        end else begin
            lane0_pipe[0] <= v2_aligned[0];
            for (int s = 1; s < MUL_LATENCY; s++) begin
                lane0_pipe[s] <= lane0_pipe[s-1];
            end
        end
    end

    assign scaled[0] = lane0_pipe[MUL_LATENCY-1];

    // Output register.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            twiddle <= '0;
        end else begin
            twiddle <= scaled;
        end
    end

endmodule

//--- rtl/twiddle_gen_top.sv
`timescale 1ns/1ps

module twiddle_gen_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  twiddle_pkg::fft_stage_e fft_stage,
    input  twiddle_pkg::lane_vec_t  v0_lanes,
    input  twiddle_pkg::lane_vec_t  v1_lanes,
    input  twiddle_pkg::lane_vec_t  v2_lanes,
    input  twiddle_pkg::word_t      modulus,
    output twiddle_pkg::lane_vec_t  twiddle
);
    import twiddle_pkg::*;

    operand_set_t sel;
    lane_vec_t    prod;
    lane_vec_t    v2_aligned;

    // One cycle: stage rule and operand register.
    operand_select u_operand_select (
        .clk       (clk),
        .rst_n     (rst_n),
        .fft_stage (fft_stage),
        .v0_lanes  (v0_lanes),
        .v1_lanes  (v1_lanes),
        .v2_lanes  (v2_lanes),
        .sel       (sel)
    );

    // Two cycles: first product and aligned v2.
    product_stage u_product_stage (
        .clk        (clk),
        .rst_n      (rst_n),
        .sel        (sel),
        .modulus    (modulus),
        .prod       (prod),
        .v2_aligned (v2_aligned)
    );

    // Three cycles: second product and output register.
    scale_stage u_scale_stage (
        .clk        (clk),
        .rst_n      (rst_n),
        .prod       (prod),
        .v2_aligned (v2_aligned),
        .modulus    (modulus),
        .twiddle    (twiddle)
    );

endmodule

//--- rtl/twiddle_pkg.sv
package twiddle_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Sizes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int WORD_W = 16;
    localparam int LANES = 4;

    // Cycles from operands to remainder inside one modular multiplier.
    localparam int MUL_LATENCY = 2;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Types
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef logic [WORD_W-1:0] word_t;

    // Index i holds lane i.
    typedef word_t [LANES-1:0] lane_vec_t;

    typedef enum logic [1:0] {
        FFT_STAGE_0,
        FFT_STAGE_1,
        FFT_STAGE_2,
        FFT_STAGE_3
    } fft_stage_e;

    // Operands of one item after the stage rule has been applied.
    typedef struct packed {
        lane_vec_t v0;
        lane_vec_t v1;
        lane_vec_t v2;
    } operand_set_t;

endpackage

//--- verification/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic clk
);

    // Free-running clock with a 4 ns period.
    initial begin
        clk = 1'b0;
    end

    always begin
        #2 clk = ~clk;
    end

endmodule

//--- verification/twiddle_gen_tb.sv
`timescale 1ns/1ps

module twiddle_gen_tb;
    import twiddle_pkg::*;

    localparam int LATENCY      = 6;
    localparam int RESET_CYCLES = 16;
    localparam int BURSTS       = 12;
    localparam int BURST_LEN    = 40;
    localparam int IDLE_CYCLES  = 8;
    localparam int RUN_LIMIT_NS = 20000;

    logic       clk;
    logic       rst_n;
    fft_stage_e fft_stage;
    lane_vec_t  v0_lanes;
    lane_vec_t  v1_lanes;
    lane_vec_t  v2_lanes;
    word_t      modulus;
    lane_vec_t  twiddle;

    integer     seed;
    int         items_checked;
    lane_vec_t  expected_q[$];

    tb_clock u_clock (
        .clk (clk)
    );

    twiddle_gen_top twiddle_gen_top_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .fft_stage (fft_stage),
        .v0_lanes  (v0_lanes),
        .v1_lanes  (v1_lanes),
        .v2_lanes  (v2_lanes),
        .modulus   (modulus),
        .twiddle   (twiddle)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Stage 0 uses all three factors, stage 1 drops v2, stage 2 keeps
    // only v0 and stage 3 yields the identity. Lane 0 is a plain v2 bypass.
    function automatic lane_vec_t expected_twiddle(input fft_stage_e stage,
                                                   input lane_vec_t v0,
                                                   input lane_vec_t v1,
                                                   input lane_vec_t v2,
                                                   input word_t n);
        lane_vec_t   res;
        logic [31:0] first;
        logic [31:0] result;
        for (int i = 1; i < LANES; i++) begin
            case (stage)
                FFT_STAGE_0: begin
                    first = (32'(v0[i]) * 32'(v1[i])) % 32'(n);
                    result = (first * 32'(v2[i])) % 32'(n);
                end
                FFT_STAGE_1: result = (32'(v0[i]) * 32'(v1[i])) % 32'(n);
                FFT_STAGE_2: result = 32'(v0[i]) % 32'(n);
                default: result = 32'd1;
            endcase
            res[i] = result[WORD_W-1:0];
        end
        res[0] = (stage == FFT_STAGE_0) ? v2[0] : word_t'(1);
        return res;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("sim failed");
        $fatal(1, "Run stopped at the first error.");
    endtask

    task automatic check_lanes(input string name, input lane_vec_t got,
                               input lane_vec_t exp);
        for (int i = 1; i < LANES; i++) begin
            if (got[i] !== exp[i]) begin
                fail_run($sformatf("** Error: %s[%0d] got %h expected %h",
                                   name, i, got[i], exp[i]));
            end
        end
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            fail_run($sformatf("** Error: %s got %h expected %h", name, got, exp));
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic draw_vec(output lane_vec_t v);
        for (int i = 0; i < LANES; i++) begin
            v[i] = word_t'($random(seed));
        end
    endtask

    // One clock cycle. The output seen now belongs to the item that was
    // driven LATENCY cycles ago, which sits at the head of the queue.
    task automatic step(input fft_stage_e stage, input lane_vec_t v0,
                        input lane_vec_t v1, input lane_vec_t v2, input word_t n);
        lane_vec_t exp_out;
        @(posedge clk);
        #1;
        exp_out = expected_q.pop_front();
        check_lanes("twiddle", twiddle, exp_out);
        check_word("twiddle[0]", twiddle[0], exp_out[0]);
        items_checked++;
        fft_stage = stage;
        v0_lanes = v0;
        v1_lanes = v1;
        v2_lanes = v2;
        modulus = n;
        expected_q.push_back(expected_twiddle(stage, v0, v1, v2, n));
    endtask

    // Zero items give zero under any modulus, so the modulus may change
    // once the last burst item has left.
    task automatic drain_pipeline(input word_t n);
        for (int c = 0; c < IDLE_CYCLES; c++) begin
            step(FFT_STAGE_0, '0, '0, '0, n);
        end
    endtask

    task automatic run_burst();
        word_t      n;
        logic [1:0] stage_bits;
        lane_vec_t  v0;
        lane_vec_t  v1;
        lane_vec_t  v2;
        n = word_t'(2 + ($unsigned($random(seed)) % 65534));
        for (int k = 0; k < BURST_LEN; k++) begin
            stage_bits = 2'($random(seed));
            draw_vec(v0);
            draw_vec(v1);
            draw_vec(v2);
            step(fft_stage_e'(stage_bits), v0, v1, v2, n);
        end
        drain_pipeline(n);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Main sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        seed = 32'h91e389ce;
        items_checked = 0;
        rst_n = 1'b0;
        fft_stage = FFT_STAGE_0;
        v0_lanes = '0;
        v1_lanes = '0;
        v2_lanes = '0;
        modulus = '0;

        // Items already in flight at release are the zeros held during reset.
        for (int i = 0; i < LATENCY; i++) begin
            expected_q.push_back('0);
        end

        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(posedge clk);
            #1;
            check_lanes("twiddle", twiddle, '0);
            check_word("twiddle[0]", twiddle[0], '0);
        end
        rst_n = 1'b1;

        for (int b = 0; b < BURSTS; b++) begin
            run_burst();
        end

        $display("Checked %0d output cycles.", items_checked);
        $display("sim passed");
        $finish;
    end

    initial begin
        #(RUN_LIMIT_NS);
        fail_run("Simulation ran past its time limit without finishing.");
    end

endmodule
